// ==== hw_ctrl_bus_pkg.sv ====
//////////////////////////////////////////////////
// Register bus request and GPIO port types, shared
// by the decoder, the register blocks and the top
//////////////////////////////////////////////////

package hw_ctrl_bus_pkg;

    localparam int data_w = 32;
    localparam int addr_w = 16;

    // One request per cycle, strobes are single-cycle
    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] wdata;
        logic              re;
        logic              we;
    } opb_req_t;

    // Interlock inputs, most of them active low on the board
    typedef struct packed {
        logic [5:0] en_state;
        logic       pendant_inst;
        logic       pendant_meb_n;
        logic [1:0] sts_n;
        logic [4:0] door_sw_n;
        logic [1:0] ls_n;
        logic       spd_ac_dr_n;
        logic       emo_good_n;
    } gpio_status_t;

    // Configuration switch banks
    typedef struct packed {
        logic [7:0] mel;
        logic [7:0] bel;
        logic [7:0] kvbel;
    } switch_cfg_t;

    typedef struct packed {
        logic [2:0] loc_cntl;
        logic [3:0] en_cntl;
        logic       gant_rot_en;
    } ctrl_out_t;

endpackage

// ==== hw_ctrl_map_pkg.sv ====
//////////////////////////////////////////////////
// Register address map, identity words and tick
// divisor defaults for the interlock control core
//////////////////////////////////////////////////

package hw_ctrl_map_pkg;

    // Region codes, address bits 11..8
    localparam logic [3:0] region_id   = 4'h0;
    localparam logic [3:0] region_gpio = 4'h1;

    // Identity region, address bits 3..0
    localparam logic [3:0] reg_version = 4'h0;
    localparam logic [3:0] reg_fpga_id = 4'h1;
    localparam logic [3:0] reg_date    = 4'h2;
    localparam logic [3:0] reg_scratch = 4'h3;

    // GPIO region
    localparam logic [3:0] reg_status = 4'h0;
    localparam logic [3:0] reg_switch = 4'h1;
    localparam logic [3:0] reg_ctrl   = 4'h2;

    localparam logic [31:0] fw_version    = 32'h0001_0000;
    localparam logic [31:0] fpga_id       = 32'h0000_0050;
    localparam logic [31:0] build_date    = 32'h2025_0822;
    localparam logic [31:0] unmapped_data = 32'hDEAD_0000;

    // 100000 does not fit 16 bits, so the divisors are 17 wide
    localparam int                tick_w           = 17;
    localparam logic [tick_w-1:0] div_ms_default   = 17'd100000;
    localparam logic [tick_w-1:0] div_slow_default = 17'd1000;

    // Slow ticks before the board wakes on its own
    localparam logic [3:0] wake_ticks = 4'd2;

endpackage

// ==== opb_decode.sv ====
//////////////////////////////////////////////////
// Region decode of the register bus into block
// strobes, with a registered read-return mux
//////////////////////////////////////////////////

`timescale 1ns/1ps

module opb_decode (
    input  logic                               opb_clk,
    input  logic                               rst_n,
    input  hw_ctrl_bus_pkg::opb_req_t          req,
    input  logic [hw_ctrl_bus_pkg::data_w-1:0] id_rdata,
    input  logic [hw_ctrl_bus_pkg::data_w-1:0] gpio_rdata,
    output logic                               id_re,
    output logic                               id_we,
    output logic                               gpio_re,
    output logic                               gpio_we,
    output logic                               bus_access,
    output logic [hw_ctrl_bus_pkg::data_w-1:0] rdata,
    output logic                               rvalid
);

    logic [3:0] region;
    logic [3:0] rd_region;
    logic       id_hit;
    logic       gpio_hit;

    assign region   = req.addr[11:8];
    assign id_hit   = (region == hw_ctrl_map_pkg::region_id);
    assign gpio_hit = (region == hw_ctrl_map_pkg::region_gpio);

    assign id_re      = req.re & id_hit;
    assign id_we      = req.we & id_hit;
    assign gpio_re    = req.re & gpio_hit;
    assign gpio_we    = req.we & gpio_hit;
    assign bus_access = req.re | req.we;

    always_ff @(posedge opb_clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid <= 1'b0;
        end else begin
            rvalid <= req.re;
        end
    end

    // Region of the read in flight
    always_ff @(posedge opb_clk) begin
        if (req.re) begin
            rd_region <= region;
        end
    end

    // Blocks have already registered their word
    always_comb begin
        case (rd_region)
            hw_ctrl_map_pkg::region_id:   rdata = id_rdata;
            hw_ctrl_map_pkg::region_gpio: rdata = gpio_rdata;
            default:                      rdata = hw_ctrl_map_pkg::unmapped_data;
        endcase
    end

endmodule

// ==== id_scratch_regs.sv ====
//////////////////////////////////////////////////
// Firmware identity words and a read/write scratch
// register for bus sanity checks
//////////////////////////////////////////////////

`timescale 1ns/1ps

module id_scratch_regs (
    input  logic                               opb_clk,
    input  logic                               rst_n,
    input  logic                               re,
    input  logic                               we,
    input  logic [3:0]                         index,
    input  logic [hw_ctrl_bus_pkg::data_w-1:0] wdata,
    output logic [hw_ctrl_bus_pkg::data_w-1:0] rdata
);

    logic [hw_ctrl_bus_pkg::data_w-1:0] scratch;

    // Only the scratch index takes writes
    always_ff @(posedge opb_clk or negedge rst_n) begin
        if (!rst_n) begin
            scratch <= '0;
        end else if (we && index == hw_ctrl_map_pkg::reg_scratch) begin
            scratch <= wdata;
        end
    end

    always_ff @(posedge opb_clk) begin
        if (re) begin
            case (index)
                hw_ctrl_map_pkg::reg_version: rdata <= hw_ctrl_map_pkg::fw_version;
                hw_ctrl_map_pkg::reg_fpga_id: rdata <= hw_ctrl_map_pkg::fpga_id;
                hw_ctrl_map_pkg::reg_date:    rdata <= hw_ctrl_map_pkg::build_date;
                hw_ctrl_map_pkg::reg_scratch: rdata <= scratch;
                default:                      rdata <= hw_ctrl_map_pkg::unmapped_data;
            endcase
        end
    end

endmodule

// ==== gpio_regs.sv ====
//////////////////////////////////////////////////
// Interlock status and switch readback through
// synchronizers, plus the control output register
//////////////////////////////////////////////////

`timescale 1ns/1ps

module gpio_regs (
    input  logic                               opb_clk,
    input  logic                               rst_n,
    input  logic                               re,
    input  logic                               we,
    input  logic [3:0]                         index,
    input  logic [hw_ctrl_bus_pkg::data_w-1:0] wdata,
    input  hw_ctrl_bus_pkg::gpio_status_t      status_in,
    input  hw_ctrl_bus_pkg::switch_cfg_t       switch_in,
    output logic [hw_ctrl_bus_pkg::data_w-1:0] rdata,
    output hw_ctrl_bus_pkg::ctrl_out_t         ctrl,
    output logic [1:0]                         led_sel
);

    hw_ctrl_bus_pkg::gpio_status_t status_meta;
    hw_ctrl_bus_pkg::gpio_status_t status_sync;
    hw_ctrl_bus_pkg::switch_cfg_t  switch_meta;
    hw_ctrl_bus_pkg::switch_cfg_t  switch_sync;

    // Bits 9..8 pick the LEDs, bits 7..0 the outputs
    logic [9:0] ctrl_reg;

    //////////////////////////////////////////////////
    // Input synchronizers
    //////////////////////////////////////////////////

    always_ff @(posedge opb_clk) begin
        status_meta <= status_in;
        status_sync <= status_meta;
        switch_meta <= switch_in;
        switch_sync <= switch_meta;
    end

    //////////////////////////////////////////////////
    // Control register and readback
    //////////////////////////////////////////////////

    always_ff @(posedge opb_clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_reg <= '0;
        end else if (we && index == hw_ctrl_map_pkg::reg_ctrl) begin
            ctrl_reg <= wdata[9:0];
        end
    end

    assign ctrl    = ctrl_reg[7:0];
    assign led_sel = ctrl_reg[9:8];

    // Right-aligned, upper bits zero
    always_ff @(posedge opb_clk) begin
        if (re) begin
            case (index)
                hw_ctrl_map_pkg::reg_status:
                    rdata <= {{(hw_ctrl_bus_pkg::data_w - $bits(status_sync)){1'b0}}, status_sync};
                hw_ctrl_map_pkg::reg_switch:
                    rdata <= {{(hw_ctrl_bus_pkg::data_w - $bits(switch_sync)){1'b0}}, switch_sync};
                hw_ctrl_map_pkg::reg_ctrl:
                    rdata <= {{(hw_ctrl_bus_pkg::data_w - $bits(ctrl_reg)){1'b0}}, ctrl_reg};
                default:
                    rdata <= hw_ctrl_map_pkg::unmapped_data;
            endcase
        end
    end

endmodule

// ==== tick_gen.sv ====
//////////////////////////////////////////////////
// Millisecond and slow tick strobes from opb_clk
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tick_gen #(
    parameter logic [hw_ctrl_map_pkg::tick_w-1:0] div_ms   = hw_ctrl_map_pkg::div_ms_default,
    parameter logic [hw_ctrl_map_pkg::tick_w-1:0] div_slow = hw_ctrl_map_pkg::div_slow_default
) (
    input  logic opb_clk,
    input  logic rst_n,
    output logic ms_tick,
    output logic slow_tick
);

    logic [hw_ctrl_map_pkg::tick_w-1:0] ms_cnt;
    logic [hw_ctrl_map_pkg::tick_w-1:0] slow_cnt;

    always_ff @(posedge opb_clk or negedge rst_n) begin
        if (!rst_n) begin
            ms_cnt    <= '0;
            slow_cnt  <= '0;
            ms_tick   <= 1'b0;
            slow_tick <= 1'b0;
        end else begin
            ms_tick   <= 1'b0;
            slow_tick <= 1'b0;
            if (ms_cnt == div_ms - 1'b1) begin
                ms_cnt  <= '0;
                ms_tick <= 1'b1;
            end else begin
                ms_cnt <= ms_cnt + 1'b1;
            end
            // Slow counter advances once per ms tick
            if (ms_tick) begin
                if (slow_cnt == div_slow - 1'b1) begin
                    slow_cnt  <= '0;
                    slow_tick <= 1'b1;
                end else begin
                    slow_cnt <= slow_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// ==== status_led.sv ====
//////////////////////////////////////////////////
// Status LEDs, blinking until the first bus access
// or a few slow ticks, then driven by the GPIO block
//////////////////////////////////////////////////

`timescale 1ns/1ps

module status_led (
    input  logic       opb_clk,
    input  logic       rst_n,
    input  logic       slow_tick,
    input  logic       bus_access,
    input  logic [1:0] led_sel,
    output logic [1:0] stat_led
);

    logic [3:0] tick_cnt;
    logic       blink;
    logic       awake;

    always_ff @(posedge opb_clk or negedge rst_n) begin
        if (!rst_n) begin
            tick_cnt <= '0;
            blink    <= 1'b0;
            awake    <= 1'b0;
        end else begin
            if (slow_tick) begin
                blink <= ~blink;
                // Saturates, never wraps back under the wake count
                if (tick_cnt != 4'hF) begin
                    tick_cnt <= tick_cnt + 4'd1;
                end
            end
            if (bus_access) begin
                awake <= 1'b1;
            end else if (slow_tick && tick_cnt >= hw_ctrl_map_pkg::wake_ticks - 4'd1) begin
                awake <= 1'b1;
            end
        end
    end

    assign stat_led = awake ? led_sel : {2{blink}};

endmodule

// ==== hw_ctrl_top.sv ====
//////////////////////////////////////////////////
// Register-bus core of the interlock control FPGA,
// decoder plus identity, GPIO, tick and LED blocks
//////////////////////////////////////////////////

`timescale 1ns/1ps

module hw_ctrl_top #(
    parameter logic [hw_ctrl_map_pkg::tick_w-1:0] div_ms   = hw_ctrl_map_pkg::div_ms_default,
    parameter logic [hw_ctrl_map_pkg::tick_w-1:0] div_slow = hw_ctrl_map_pkg::div_slow_default
) (
    input  logic                               opb_clk,
    input  logic                               rst_n,
    input  hw_ctrl_bus_pkg::opb_req_t          opb_req,
    input  hw_ctrl_bus_pkg::gpio_status_t      gpio_status,
    input  hw_ctrl_bus_pkg::switch_cfg_t       switch_cfg,
    output logic [hw_ctrl_bus_pkg::data_w-1:0] opb_rdata,
    output logic                               opb_rvalid,
    output hw_ctrl_bus_pkg::ctrl_out_t         ctrl_out,
    output logic [1:0]                         stat_led
);

    logic                               id_re;
    logic                               id_we;
    logic                               gpio_re;
    logic                               gpio_we;
    logic                               bus_access;
    logic [hw_ctrl_bus_pkg::data_w-1:0] id_rdata;
    logic [hw_ctrl_bus_pkg::data_w-1:0] gpio_rdata;
    logic [1:0]                         led_sel;
    logic                               slow_tick;

    opb_decode u_decode (
        .opb_clk    (opb_clk),
        .rst_n      (rst_n),
        .req        (opb_req),
        .id_rdata   (id_rdata),
        .gpio_rdata (gpio_rdata),
        .id_re      (id_re),
        .id_we      (id_we),
        .gpio_re    (gpio_re),
        .gpio_we    (gpio_we),
        .bus_access (bus_access),
        .rdata      (opb_rdata),
        .rvalid     (opb_rvalid)
    );

    // Register index is the low address nibble
    id_scratch_regs u_id (
        .opb_clk (opb_clk),
        .rst_n   (rst_n),
        .re      (id_re),
        .we      (id_we),
        .index   (opb_req.addr[3:0]),
        .wdata   (opb_req.wdata),
        .rdata   (id_rdata)
    );

    gpio_regs u_gpio (
        .opb_clk   (opb_clk),
        .rst_n     (rst_n),
        .re        (gpio_re),
        .we        (gpio_we),
        .index     (opb_req.addr[3:0]),
        .wdata     (opb_req.wdata),
        .status_in (gpio_status),
        .switch_in (switch_cfg),
        .rdata     (gpio_rdata),
        .ctrl      (ctrl_out),
        .led_sel   (led_sel)
    );

    // Only the slow tick is used here
    tick_gen #(
        .div_ms   (div_ms),
        .div_slow (div_slow)
    ) u_tick (
        .opb_clk   (opb_clk),
        .rst_n     (rst_n),
        .ms_tick   (),
        .slow_tick (slow_tick)
    );

    status_led u_led (
        .opb_clk    (opb_clk),
        .rst_n      (rst_n),
        .slow_tick  (slow_tick),
        .bus_access (bus_access),
        .led_sel    (led_sel),
        .stat_led   (stat_led)
    );

endmodule

// ==== hw_ctrl_assert.sv ====
//////////////////////////////////////////////////
// Bus protocol and register checks, bound to the top
//////////////////////////////////////////////////

`timescale 1ns/1ps

module hw_ctrl_assert (
    input logic                               opb_clk,
    input logic                               rst_n,
    input hw_ctrl_bus_pkg::opb_req_t          opb_req,
    input logic [hw_ctrl_bus_pkg::data_w-1:0] opb_rdata,
    input logic                               opb_rvalid,
    input hw_ctrl_bus_pkg::ctrl_out_t         ctrl_out
);

    int unsigned fail_cnt = 0;

    logic [hw_ctrl_bus_pkg::data_w-1:0] scratch_sh;
    logic [9:0]                         ctrl_sh;
    logic [hw_ctrl_bus_pkg::data_w-1:0] exp_d;
    logic [hw_ctrl_bus_pkg::data_w-1:0] exp_q;
    logic                               known_d;
    logic                               known_q;
    logic                               re_q;
    logic [3:0]                         region;
    logic [3:0]                         index;
    logic                               ctrl_wr;
    logic                               scratch_wr;

    assign region     = opb_req.addr[11:8];
    assign index      = opb_req.addr[3:0];
    assign ctrl_wr    = opb_req.we && region == hw_ctrl_map_pkg::region_gpio
                        && index == hw_ctrl_map_pkg::reg_ctrl;
    assign scratch_wr = opb_req.we && region == hw_ctrl_map_pkg::region_id
                        && index == hw_ctrl_map_pkg::reg_scratch;

    // Expected word for the read on the bus now
    always_comb begin
        known_d = 1'b1;
        exp_d   = hw_ctrl_map_pkg::unmapped_data;
        if (region == hw_ctrl_map_pkg::region_id) begin
            case (index)
                hw_ctrl_map_pkg::reg_version: exp_d = hw_ctrl_map_pkg::fw_version;
                hw_ctrl_map_pkg::reg_fpga_id: exp_d = hw_ctrl_map_pkg::fpga_id;
                hw_ctrl_map_pkg::reg_date:    exp_d = hw_ctrl_map_pkg::build_date;
                hw_ctrl_map_pkg::reg_scratch: exp_d = scratch_sh;
                default:                      exp_d = hw_ctrl_map_pkg::unmapped_data;
            endcase
        end else if (region == hw_ctrl_map_pkg::region_gpio) begin
            if (index == hw_ctrl_map_pkg::reg_ctrl) begin
                exp_d = {{(hw_ctrl_bus_pkg::data_w - 10){1'b0}}, ctrl_sh};
            end else if (index == hw_ctrl_map_pkg::reg_status ||
                         index == hw_ctrl_map_pkg::reg_switch) begin
                // Input readback is not modelled here
                known_d = 1'b0;
            end
        end
    end

    always_ff @(posedge opb_clk or negedge rst_n) begin
        if (!rst_n) begin
            scratch_sh <= '0;
            ctrl_sh    <= '0;
            re_q       <= 1'b0;
            exp_q      <= '0;
            known_q    <= 1'b0;
        end else begin
            re_q <= opb_req.re;
            if (opb_req.re) begin
                exp_q   <= exp_d;
                known_q <= known_d;
            end
            if (scratch_wr) begin
                scratch_sh <= opb_req.wdata;
            end
            if (ctrl_wr) begin
                ctrl_sh <= opb_req.wdata[9:0];
            end
        end
    end

    rvalid_timing: assert property (@(posedge opb_clk) disable iff (!rst_n)
        opb_rvalid == re_q)
        else begin
            fail_cnt++;
            $error("opb_rvalid does not follow a read strobe by one cycle");
        end

    rdata_value: assert property (@(posedge opb_clk) disable iff (!rst_n)
        (opb_rvalid && known_q) |-> opb_rdata == exp_q)
        else begin
            fail_cnt++;
            $error("opb_rdata %h differs from the mapped value %h", opb_rdata, exp_q);
        end

    ctrl_update: assert property (@(posedge opb_clk) disable iff (!rst_n)
        ctrl_wr |=> ctrl_out == ctrl_sh[7:0])
        else begin
            fail_cnt++;
            $error("ctrl_out does not match the last control write");
        end

    strobe_excl: assert property (@(posedge opb_clk) disable iff (!rst_n)
        !(opb_req.re && opb_req.we))
        else begin
            fail_cnt++;
            $error("Read and write strobes are high together");
        end

endmodule

// ==== hw_ctrl_tb.sv ====
//////////////////////////////////////////////////
// Testbench for the register-bus core, fast ticks
//////////////////////////////////////////////////

`timescale 1ns/1ps

module hw_ctrl_tb;

    localparam int timeout_cycles = 100;

    logic                          opb_clk;
    logic                          rst_n;
    hw_ctrl_bus_pkg::opb_req_t     opb_req;
    hw_ctrl_bus_pkg::gpio_status_t gpio_status;
    hw_ctrl_bus_pkg::switch_cfg_t  switch_cfg;
    logic [31:0]                   opb_rdata;
    logic                          opb_rvalid;
    hw_ctrl_bus_pkg::ctrl_out_t    ctrl_out;
    logic [1:0]                    stat_led;

    int          errors = 0;
    int          checks = 0;
    int          test_start = 0;
    logic [31:0] rnd;
    logic [31:0] rnd2;

    // Slow tick every 12 cycles
    hw_ctrl_top #(.div_ms(4), .div_slow(3)) uut (
        .opb_clk     (opb_clk),
        .rst_n       (rst_n),
        .opb_req     (opb_req),
        .gpio_status (gpio_status),
        .switch_cfg  (switch_cfg),
        .opb_rdata   (opb_rdata),
        .opb_rvalid  (opb_rvalid),
        .ctrl_out    (ctrl_out),
        .stat_led    (stat_led)
    );

    bind hw_ctrl_top hw_ctrl_assert u_assert (
        .opb_clk    (opb_clk),
        .rst_n      (rst_n),
        .opb_req    (opb_req),
        .opb_rdata  (opb_rdata),
        .opb_rvalid (opb_rvalid),
        .ctrl_out   (ctrl_out)
    );

    initial begin
        opb_clk = 1'b0;
        forever #5 opb_clk = ~opb_clk;
    end

    function automatic logic [15:0] addr_of(input logic [3:0] region, input logic [3:0] index);
        return {4'h0, region, 4'h0, index};
    endfunction

    function automatic int total_errors();
        return errors + int'(uut.u_assert.fail_cnt);
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic send_req(input logic re, input logic we, input logic [15:0] addr,
                            input logic [31:0] data);
        hw_ctrl_bus_pkg::opb_req_t req;
        req.addr  = addr;
        req.wdata = data;
        req.re    = re;
        req.we    = we;
        @(posedge opb_clk);
        opb_req <= req;
    endtask

    task automatic release_bus();
        @(posedge opb_clk);
        opb_req <= '0;
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [31:0] data);
        send_req(1'b0, 1'b1, addr, data);
        release_bus();
    endtask

    task automatic wait_rvalid(output bit seen);
        int n;
        n = 0;
        @(negedge opb_clk);
        while (!opb_rvalid && n < timeout_cycles) begin
            @(negedge opb_clk);
            n++;
        end
        seen = opb_rvalid;
        if (!seen) begin
            errors++;
            $display("Timed out waiting for opb_rvalid after a read at t=%0t", $time);
        end
    endtask

    task automatic read_expect(input string name, input logic [15:0] addr,
                               input logic [31:0] exp);
        bit seen;
        send_req(1'b1, 1'b0, addr, 32'h0);
        release_bus();
        wait_rvalid(seen);
        if (seen) check_val(name, opb_rdata, exp);
    endtask

    // Two reads on consecutive cycles
    task automatic read_pair(input logic [15:0] a0, input logic [31:0] e0,
                             input logic [15:0] a1, input logic [31:0] e1);
        bit seen;
        send_req(1'b1, 1'b0, a0, 32'h0);
        send_req(1'b1, 1'b0, a1, 32'h0);
        wait_rvalid(seen);
        if (seen) check_val("opb_rdata first of pair", opb_rdata, e0);
        release_bus();
        wait_rvalid(seen);
        if (seen) check_val("opb_rdata second of pair", opb_rdata, e1);
    endtask

    task automatic wait_led(input logic [1:0] want);
        int n;
        n = 0;
        while (stat_led !== want && n < timeout_cycles) begin
            @(negedge opb_clk);
            n++;
        end
        if (stat_led !== want) begin
            errors++;
            $display("stat_led never reached %b within %0d cycles", want, timeout_cycles);
        end
    endtask

    // LEDs must keep one value for a number of cycles
    task automatic expect_led_steady(input logic [1:0] want, input int cycles);
        int n;
        n = 0;
        while (stat_led === want && n < cycles) begin
            @(negedge opb_clk);
            n++;
        end
        check_val("stat_led", {30'h0, stat_led}, {30'h0, want});
    endtask

    task automatic report_test(input string name);
        int now;
        now = total_errors();
        if (now == test_start) $display("Test %s: ok", name);
        else $display("Test %s: %0d failure(s)", name, now - test_start);
        test_start = now;
    endtask

    initial begin
        rst_n       = 1'b0;
        opb_req     = '0;
        gpio_status = '0;
        switch_cfg  = '0;
        void'($urandom(32'he303_6897));
        repeat (5) @(posedge opb_clk);
        rst_n <= 1'b1;

        // No bus traffic yet, LEDs blink until the second slow tick
        wait_led(2'b11);
        wait_led(2'b00);
        // Awake after the second slow tick, so the third one no longer toggles
        expect_led_steady(2'b00, 14);
        rnd = $urandom();
        bus_write(addr_of(hw_ctrl_map_pkg::region_gpio, hw_ctrl_map_pkg::reg_ctrl), rnd);
        @(negedge opb_clk);
        check_val("stat_led", {30'h0, stat_led}, {30'h0, rnd[9:8]});
        report_test("led wake-up");

        for (int pass = 0; pass < 2; pass++) begin
            read_expect("opb_rdata version", addr_of(4'h0, 4'h0), hw_ctrl_map_pkg::fw_version);
            read_expect("opb_rdata fpga id", addr_of(4'h0, 4'h1), hw_ctrl_map_pkg::fpga_id);
            read_expect("opb_rdata date", addr_of(4'h0, 4'h2), hw_ctrl_map_pkg::build_date);
            for (int i = 0; i < 3; i++) begin
                bus_write(addr_of(hw_ctrl_map_pkg::region_id, 4'(i)), $urandom());
            end
        end
        report_test("identity");

        for (int i = 0; i < 4; i++) begin
            rnd = $urandom();
            bus_write(addr_of(4'h0, hw_ctrl_map_pkg::reg_scratch), rnd);
            read_expect("opb_rdata scratch", addr_of(4'h0, hw_ctrl_map_pkg::reg_scratch), rnd);
        end
        read_pair(addr_of(4'h0, 4'h3), rnd, addr_of(4'h0, 4'h0), hw_ctrl_map_pkg::fw_version);
        read_pair(addr_of(4'h0, 4'h2), hw_ctrl_map_pkg::build_date, addr_of(4'h0, 4'h3), rnd);
        report_test("scratch");

        for (int i = 0; i < 4; i++) begin
            rnd  = $urandom();
            rnd2 = $urandom();
            @(posedge opb_clk);
            gpio_status <= rnd[18:0];
            switch_cfg  <= rnd2[23:0];
            // Read strobe goes out two cycles after the input change
            repeat (1) @(posedge opb_clk);
            read_expect("opb_rdata status", addr_of(4'h1, 4'h0), {13'h0, rnd[18:0]});
            read_expect("opb_rdata switch", addr_of(4'h1, 4'h1), {8'h0, rnd2[23:0]});
        end
        report_test("gpio inputs");

        for (int i = 0; i < 4; i++) begin
            rnd = $urandom();
            bus_write(addr_of(4'h1, hw_ctrl_map_pkg::reg_ctrl), rnd);
            @(negedge opb_clk);
            check_val("ctrl_out", {24'h0, ctrl_out}, {24'h0, rnd[7:0]});
            read_expect("opb_rdata ctrl", addr_of(4'h1, 4'h2), {22'h0, rnd[9:0]});
        end
        report_test("control");

        read_expect("opb_rdata region 2", addr_of(4'h2, 4'h0), hw_ctrl_map_pkg::unmapped_data);
        read_expect("opb_rdata region F", addr_of(4'hF, 4'h3), hw_ctrl_map_pkg::unmapped_data);
        read_expect("opb_rdata id index 5", addr_of(4'h0, 4'h5), hw_ctrl_map_pkg::unmapped_data);
        read_expect("opb_rdata gpio index 7", addr_of(4'h1, 4'h7), hw_ctrl_map_pkg::unmapped_data);
        report_test("unmapped");

        repeat (3) @(posedge opb_clk);
        $display("Checks: %0d, failures: %0d", checks, total_errors());
        if (total_errors() == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // Overall limit on the run
    initial begin
        #50us;
        $display("Simulation time limit reached before the tests completed");
        $display("Errors found");
        $finish;
    end

endmodule

// ==== hw_ctrl.f ====
hw_ctrl_bus_pkg.sv
hw_ctrl_map_pkg.sv
opb_decode.sv
id_scratch_regs.sv
gpio_regs.sv
tick_gen.sv
status_led.sv
hw_ctrl_top.sv
hw_ctrl_assert.sv
hw_ctrl_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= hw_ctrl_tb
FILELIST  ?= hw_ctrl.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= No errors
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG PASS_MSG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
